/* design/ex_defines.svh */
// execute stage widths and constants

`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// ********************
// widths
// ********************

// data and address width
`define EX_XLEN         32
// register index width
`define EX_REG_ADDR_W   5
// shift amount width
`define EX_SHAMT_W      5

// ********************
// constants
// ********************

// link value step past the jump
`define EX_INST_STEP    32'd4
// upper immediate keeps bits 31..12
`define EX_UPPER_MASK   32'hffff_f000

`endif

/* design/ex_pkg.sv */
// execute stage types

`include "ex_defines.svh"

package ex_pkg;

    // rv32i major opcodes handled here
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_AUIPC, ALU_LINK, ALU_BRANCH
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_cond_e;

    typedef struct packed {
        logic [`EX_XLEN-1:0]       pc;
        opcode_e                   opcode;
        logic [2:0]                funct3;
        logic [6:0]                funct7;
        logic [`EX_REG_ADDR_W-1:0] rd;
        logic [`EX_XLEN-1:0]       imm;
        logic [`EX_XLEN-1:0]       rs1_data;
        logic [`EX_XLEN-1:0]       rs2_data;
    } ex_inst_t;

    // word held between decode and execute
    typedef struct packed {
        alu_op_e                   op;
        br_cond_e                  cond;
        logic [`EX_XLEN-1:0]       opa;
        logic [`EX_XLEN-1:0]       opb;
        logic [`EX_XLEN-1:0]       rs2_data;
        logic [`EX_XLEN-1:0]       pc;
        logic [`EX_XLEN-1:0]       imm;
        logic [`EX_REG_ADDR_W-1:0] rd;
    } ex_issue_t;

    typedef struct packed {
        logic [`EX_REG_ADDR_W-1:0] rd;
        logic [`EX_XLEN-1:0]       data;
    } ex_wb_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0] target;
    } ex_jump_t;

endpackage

/* design/ex_op_decode.sv */
// operation decoder and issue register

`timescale 1ns/1ps

module ex_op_decode (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                inst_valid_i,
    input  ex_pkg::ex_inst_t    inst_i,
    output logic                issue_valid_o,
    output ex_pkg::ex_issue_t   issue_o
);

    import ex_pkg::*;

    ex_issue_t issue_d;

    // funct3 map shared by register and immediate forms
    function automatic alu_op_e arith_op(input logic [2:0] funct3,
                                         input logic       alt,
                                         input logic       is_reg);
        alu_op_e op;
        case (funct3)
            3'b000: op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: op = alt ? ALU_SRA : ALU_SRL;
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // ********************
    // decode
    // ********************

    always_comb begin
        issue_d.op       = ALU_NONE;
        issue_d.cond     = BR_ALWAYS;
        issue_d.pc       = inst_i.pc;
        issue_d.imm      = inst_i.imm;
        issue_d.rd       = inst_i.rd;
        issue_d.rs2_data = inst_i.rs2_data;
        // jal targets from pc, everything else from rs1
        issue_d.opa      = (inst_i.opcode == OPC_JAL) ? inst_i.pc : inst_i.rs1_data;
        issue_d.opb      = (inst_i.opcode == OPC_OP) ? inst_i.rs2_data : inst_i.imm;

        case (inst_i.opcode)
            OPC_OP_IMM: begin
                issue_d.op = arith_op(inst_i.funct3, inst_i.funct7[5], 1'b0);
            end
            OPC_OP: begin
                issue_d.op = arith_op(inst_i.funct3, inst_i.funct7[5], 1'b1);
            end
            OPC_LUI: begin
                issue_d.op = ALU_LUI;
            end
            OPC_AUIPC: begin
                issue_d.op = ALU_AUIPC;
            end
            OPC_JAL, OPC_JALR: begin
                issue_d.op = ALU_LINK;
            end
            OPC_BRANCH: begin
                issue_d.op = ALU_BRANCH;
                case (inst_i.funct3)
                    3'b000: issue_d.cond = BR_EQ;
                    3'b001: issue_d.cond = BR_NE;
                    3'b100: issue_d.cond = BR_LT;
                    3'b101: issue_d.cond = BR_GE;
                    3'b110: issue_d.cond = BR_LTU;
                    3'b111: issue_d.cond = BR_GEU;
                    default: issue_d.op = ALU_NONE;
                endcase
            end
            default: begin
                issue_d.op = ALU_NONE;
            end
        endcase
    end

    // ********************
    // issue register
    // ********************

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            issue_o <= issue_d;
        end
    end

endmodule

/* design/ex_alu.sv */
// writeback alu

`timescale 1ns/1ps

`include "ex_defines.svh"

module ex_alu (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                issue_valid_i,
    input  ex_pkg::ex_issue_t   issue_i,
    output logic                wb_valid_o,
    output ex_pkg::ex_wb_t      wb_o
);

    import ex_pkg::*;

    logic [`EX_XLEN-1:0]    result;
    logic [`EX_SHAMT_W-1:0] shamt;
    logic [`EX_XLEN-1:0]    upper_imm;
    logic                   writes_rd;

    assign shamt     = issue_i.opb[`EX_SHAMT_W-1:0];
    assign upper_imm = issue_i.imm & `EX_UPPER_MASK;
    // branches and unknown opcodes leave rd alone
    assign writes_rd = (issue_i.op != ALU_NONE) && (issue_i.op != ALU_BRANCH);

    // ********************
    // result
    // ********************

    always_comb begin
        case (issue_i.op)
            ALU_ADD:   result = issue_i.opa + issue_i.opb;
            ALU_SUB:   result = issue_i.opa - issue_i.opb;
            ALU_SLT:   result = {{(`EX_XLEN-1){1'b0}},
                                 $signed(issue_i.opa) < $signed(issue_i.opb)};
            ALU_SLTU:  result = {{(`EX_XLEN-1){1'b0}}, issue_i.opa < issue_i.opb};
            ALU_XOR:   result = issue_i.opa ^ issue_i.opb;
            ALU_OR:    result = issue_i.opa | issue_i.opb;
            ALU_AND:   result = issue_i.opa & issue_i.opb;
            ALU_SLL:   result = issue_i.opa << shamt;
            ALU_SRL:   result = issue_i.opa >> shamt;
            // sign fill
            ALU_SRA:   result = $signed(issue_i.opa) >>> shamt;
            ALU_LUI:   result = upper_imm;
            ALU_AUIPC: result = issue_i.pc + upper_imm;
            // return address for jal and jalr
            ALU_LINK:  result = issue_i.pc + `EX_INST_STEP;
            default:   result = '0;
        endcase
    end

    // ********************
    // writeback register
    // ********************

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= issue_valid_i && writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            wb_o.rd   <= issue_i.rd;
            wb_o.data <= result;
        end
    end

endmodule

/* design/ex_branch.sv */
// branch and jump unit

`timescale 1ns/1ps

`include "ex_defines.svh"

module ex_branch (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                issue_valid_i,
    input  ex_pkg::ex_issue_t   issue_i,
    output logic                jump_valid_o,
    output ex_pkg::ex_jump_t    jump_o
);

    import ex_pkg::*;

    logic                taken;
    logic                is_jump;
    logic [`EX_XLEN-1:0] target;

    // condition check, rs1 against rs2
    always_comb begin
        case (issue_i.cond)
            BR_EQ:     taken = issue_i.opa == issue_i.rs2_data;
            BR_NE:     taken = issue_i.opa != issue_i.rs2_data;
            BR_LT:     taken = $signed(issue_i.opa) < $signed(issue_i.rs2_data);
            BR_GE:     taken = $signed(issue_i.opa) >= $signed(issue_i.rs2_data);
            BR_LTU:    taken = issue_i.opa < issue_i.rs2_data;
            BR_GEU:    taken = issue_i.opa >= issue_i.rs2_data;
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign is_jump = (issue_i.op == ALU_LINK) || (issue_i.op == ALU_BRANCH);

    // opa already holds pc for jal and rs1 for jalr
    assign target = (issue_i.op == ALU_LINK) ? issue_i.opa + issue_i.imm
                                             : issue_i.pc + issue_i.imm;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            jump_valid_o <= 1'b0;
        end else begin
            jump_valid_o <= issue_valid_i && is_jump && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            jump_o.target <= target;
        end
    end

endmodule

/* design/ex_stage.sv */
// two-stage execute unit

`timescale 1ns/1ps

module ex_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                inst_valid_i,
    input  ex_pkg::ex_inst_t    inst_i,
    output logic                wb_valid_o,
    output ex_pkg::ex_wb_t      wb_o,
    output logic                jump_valid_o,
    output ex_pkg::ex_jump_t    jump_o
);

    import ex_pkg::*;

    logic      issue_valid;
    ex_issue_t issue;

    // ********************
    // stage 1
    // ********************

    ex_op_decode ex_op_decode_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .issue_valid_o (issue_valid),
        .issue_o       (issue)
    );

    // ********************
    // stage 2
    // ********************

    // both units read the same issue word
    ex_alu ex_alu_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o)
    );

    ex_branch ex_branch_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .jump_valid_o  (jump_valid_o),
        .jump_o        (jump_o)
    );

endmodule

/* bench/tb_ex_stage.sv */
// execute stage testbench

`timescale 1ns/1ps

`include "ex_defines.svh"

module tb_ex_stage;

    import ex_pkg::*;

    localparam int XLEN      = `EX_XLEN;
    localparam int MAX_CASES = 64;

    // cases file line with each field padded to whole hex digits
    typedef struct packed {
        logic [3:0]      chain;
        logic [XLEN-1:0] pc;
        logic [7:0]      opcode;
        logic [3:0]      funct3;
        logic [7:0]      funct7;
        logic [7:0]      rd;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [3:0]      wb_valid;
        logic [XLEN-1:0] wb_data;
        logic [3:0]      jump_valid;
        logic [XLEN-1:0] jump_target;
    } case_row_t;

    logic      clk = 1'b0;
    logic      arst_n_i;
    logic      inst_valid_i;
    ex_inst_t  inst_i;
    logic      wb_valid_o;
    ex_wb_t    wb_o;
    logic      jump_valid_o;
    ex_jump_t  jump_o;

    logic [$bits(case_row_t)-1:0] case_mem [MAX_CASES];

    int          num_cases    = 0;
    bit          cases_loaded = 1'b0;
    int          drive_idx    = -1;
    int          pipe_idx [2] = '{-1, -1};
    int          checked      = 0;
    int          failed_cases = 0;
    int          error_count  = 0;
    int          case_errors  = 0;
    logic [31:0] lfsr;

    ex_stage ex_stage_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o),
        .jump_valid_o (jump_valid_o),
        .jump_o       (jump_o)
    );

    initial begin
        forever begin
            #50 clk = ~clk;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            case_errors++;
        end
    endtask

    task automatic drive_inst(input case_row_t row);
        inst_valid_i    <= 1'b1;
        inst_i.pc       <= row.pc;
        inst_i.opcode   <= opcode_e'(row.opcode[6:0]);
        inst_i.funct3   <= row.funct3[2:0];
        inst_i.funct7   <= row.funct7[6:0];
        inst_i.rd       <= row.rd[`EX_REG_ADDR_W-1:0];
        inst_i.imm      <= row.imm;
        inst_i.rs1_data <= row.rs1;
        inst_i.rs2_data <= row.rs2;
    endtask

    // ********************
    // checking
    // ********************

    task automatic check_case(input int idx);
        case_row_t row;
        row         = case_mem[idx];
        case_errors = 0;
        if (row.wb_valid[0] && wb_valid_o !== 1'b1) begin
            $display("case %0d: writeback strobe is missing", idx);
            case_errors++;
        end else if (!row.wb_valid[0] && wb_valid_o !== 1'b0) begin
            $display("case %0d: unexpected writeback strobe", idx);
            case_errors++;
        end else if (row.wb_valid[0]) begin
            compare_value("wb_o.rd", XLEN'(wb_o.rd), XLEN'(row.rd[`EX_REG_ADDR_W-1:0]));
            compare_value("wb_o.data", wb_o.data, row.wb_data);
        end
        if (row.jump_valid[0] && jump_valid_o !== 1'b1) begin
            $display("case %0d: jump strobe is missing", idx);
            case_errors++;
        end else if (!row.jump_valid[0] && jump_valid_o !== 1'b0) begin
            $display("case %0d: unexpected jump strobe", idx);
            case_errors++;
        end else if (row.jump_valid[0]) begin
            compare_value("jump_o.target", jump_o.target, row.jump_target);
        end
        checked++;
        error_count += case_errors;
        if (case_errors == 0) begin
            $display("case %0d pc 0x%08h passed", idx, row.pc);
        end else begin
            $display("case %0d pc 0x%08h failed with %0d errors", idx, row.pc, case_errors);
            failed_cases++;
        end
    endtask

    // results land two edges after the strobe is sampled
    always @(negedge clk) begin
        if (pipe_idx[1] >= 0) begin
            check_case(pipe_idx[1]);
        end else if (wb_valid_o !== 1'b0 || jump_valid_o !== 1'b0) begin
            $display("strobe seen with no instruction in flight");
            error_count++;
        end
        pipe_idx[1] = pipe_idx[0];
        pipe_idx[0] = inst_valid_i ? drive_idx : -1;
    end

    initial begin
        wait (cases_loaded);
        repeat (num_cases * 6 + 20) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", num_cases * 6 + 20);
        $display("TB FAILED");
        $finish;
    end

    // ********************
    // stimulus
    // ********************

    initial begin
        case_row_t row;
        int        idle;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        lfsr         = 32'h752f_65b4;
        for (int i = 0; i < MAX_CASES; i++) begin
            case_mem[i] = '0;
        end
        $readmemh("bench/ex_cases.mem", case_mem);
        // cases end at the first empty line of the memory
        for (int i = 0; i < MAX_CASES; i++) begin
            row = case_mem[i];
            if (row.opcode != 8'h00 && num_cases == i) begin
                num_cases = i + 1;
            end
        end
        cases_loaded = 1'b1;
        if (num_cases == 0) begin
            $display("no cases were loaded from the cases file");
        end

        // strobe held during reset must not reach the outputs
        @(posedge clk);
        drive_inst(case_mem[0]);
        repeat (3) @(posedge clk);
        arst_n_i     <= 1'b1;
        inst_valid_i <= 1'b0;

        for (int i = 0; i < num_cases; i++) begin
            row  = case_mem[i];
            idle = 0;
            if (!row.chain[0]) begin
                lfsr = lfsr_next(lfsr);
                idle = int'(lfsr[0]);
                lfsr = lfsr_next(lfsr);
                idle = idle + 2 * int'(lfsr[0]);
            end
            repeat (idle) begin
                @(posedge clk);
                inst_valid_i <= 1'b0;
            end
            @(posedge clk);
            drive_idx = i;
            drive_inst(row);
        end
        @(posedge clk);
        inst_valid_i <= 1'b0;
        repeat (4) @(posedge clk);

        $display("%0d of %0d cases checked, %0d failed, %0d errors",
                 checked, num_cases, failed_cases, error_count);
        if (error_count == 0 && num_cases > 0 && checked == num_cases) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* bench/ex_cases.mem */
// chain_pc_opcode_funct3_funct7_rd_imm_rs1_rs2_wbvalid_wbdata_jumpvalid_jumptarget
// chain 1 drives the case on the cycle right after the one before it
0_00001000_33_0_00_01_00000000_00000005_00000007_1_0000000c_0_00000000
1_00001004_33_0_20_02_00000000_00000005_00000007_1_fffffffe_0_00000000
1_00001008_33_2_00_03_00000000_fffffff0_00000001_1_00000001_0_00000000
0_0000100c_33_3_00_04_00000000_fffffff0_00000001_1_00000000_0_00000000
0_00001010_33_4_00_05_00000000_ff00ff00_0ff00ff0_1_f0f0f0f0_0_00000000
0_00001014_33_7_00_06_00000000_ff00ff00_0ff00ff0_1_0f000f00_0_00000000
0_00001018_33_1_00_07_00000000_00000001_00000024_1_00000010_0_00000000
0_0000101c_33_5_20_08_00000000_80000000_00000004_1_f8000000_0_00000000
0_00001020_33_5_00_09_00000000_80000000_00000004_1_08000000_0_00000000
0_00001024_13_0_7f_0a_fffffffd_00000010_12345678_1_0000000d_0_00000000
0_00001028_13_2_00_0b_00000005_ffffffff_00000000_1_00000001_0_00000000
0_0000102c_13_1_00_0c_00000023_00000011_00000000_1_00000088_0_00000000
0_00001030_13_5_00_0d_00000008_f0000000_00000000_1_00f00000_0_00000000
0_00001034_13_5_20_0e_00000408_f0000000_00000000_1_fff00000_0_00000000
0_00001038_37_0_00_0f_12345abc_00000000_00000000_1_12345000_0_00000000
0_0000103c_17_0_00_10_00002fff_00000000_00000000_1_0000303c_0_00000000
0_00001040_6f_0_00_01_00000100_deadbeef_00000000_1_00001044_1_00001140
0_00001044_67_0_00_01_fffffff8_00008000_00000000_1_00001048_1_00007ff8
0_00001048_63_0_00_00_00000040_00000005_00000005_0_00000000_1_00001088
1_0000104c_63_0_00_00_00000040_00000005_00000006_0_00000000_0_00000000
1_00001050_63_1_00_00_00000040_00000005_00000006_0_00000000_1_00001090
0_00001054_63_1_00_00_00000040_00000005_00000005_0_00000000_0_00000000
0_00001058_63_4_00_00_00000040_ffffffff_00000001_0_00000000_1_00001098
0_0000105c_63_4_00_00_00000040_00000001_ffffffff_0_00000000_0_00000000
0_00001060_63_5_00_00_00000040_00000001_ffffffff_0_00000000_1_000010a0
0_00001064_63_5_00_00_00000040_ffffffff_00000001_0_00000000_0_00000000
0_00001068_63_6_00_00_00000040_00000001_ffffffff_0_00000000_1_000010a8
0_0000106c_63_6_00_00_00000040_ffffffff_00000001_0_00000000_0_00000000
0_00001070_63_7_00_00_00000040_ffffffff_00000001_0_00000000_1_000010b0
0_00001074_63_7_00_00_00000040_00000001_ffffffff_0_00000000_0_00000000
0_00001078_03_2_00_05_00000010_00001000_00000000_0_00000000_0_00000000
1_0000107c_33_0_00_06_00000000_00000100_00000023_1_00000123_0_00000000
1_00001080_73_1_00_07_00000000_00000055_00000000_0_00000000_0_00000000
1_00001084_6f_0_00_01_fffffff0_00000000_00000000_1_00001088_1_00001074
1_00001088_33_0_20_02_00000000_00000000_00000001_1_ffffffff_0_00000000

/* sources.f */
+incdir+design
design/ex_pkg.sv
design/ex_op_decode.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_stage.sv
bench/tb_ex_stage.sv

/* Makefile */
# Verilator flow for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
